/* design/sramx_pkg.sv */
package sramx_pkg;

    typedef logic [31:0] sramx_word_t;

    // master to slave, held stable until addr_ok
    typedef struct packed {
        logic        req;
        logic        wr;
        sramx_word_t addr;
        sramx_word_t wdata;
    } sramx_req_t;

    // slave to master
    typedef struct packed {
        logic        addr_ok;
        logic        data_ok;
        sramx_word_t rdata;  // valid with data_ok on reads
    } sramx_resp_t;

    // data cache geometry, one word per line
    localparam int DC_LINES = 16;
    localparam int DC_IDX_W = $clog2(DC_LINES);
    localparam int DC_TAG_W = 32 - DC_IDX_W - 2;

    // masters sharing the memory port: ifetch, dcache, uncached
    localparam int ARB_MASTERS = 3;

endpackage

/* design/tu_pkg.sv */
package tu_pkg;

    typedef enum logic [1:0] {
        TU_OP_NONE,
        TU_OP_SET_K0,
        TU_OP_READ_K0
    } tu_op_e;

    typedef logic [2:0] tu_k0_t;

    typedef struct packed {
        tu_op_e op;
        tu_k0_t k0;
    } tu_op_req_t;

    typedef struct packed {
        logic   valid;
        tu_k0_t k0;
    } tu_op_resp_t;

    typedef struct packed {
        logic [31:0] vaddr;
    } tu_addr_req_t;

    typedef struct packed {
        logic [31:0] paddr;
        logic        is_uncached;
    } tu_addr_resp_t;

    localparam tu_k0_t      K0_CACHED = 3'd3;
    localparam tu_k0_t      K0_RESET  = 3'd3;
    localparam logic [31:0] SEG_MASK  = 32'h1fff_ffff;
    localparam logic [2:0]  SEG_KSEG0 = 3'b100;  // top bits of kseg0
    localparam logic [2:0]  SEG_KSEG1 = 3'b101;  // top bits of kseg1

endpackage

/* design/translation_unit.sv */
`timescale 1ns/10ps

module translation_unit import tu_pkg::*; (
    input  logic          aclk,
    input  logic          aresetn,
    input  tu_op_req_t    i_op,
    output tu_op_resp_t   o_op_resp,
    input  tu_addr_req_t  i_ireq,
    output tu_addr_resp_t o_iresp,
    input  tu_addr_req_t  i_dreq,
    output tu_addr_resp_t o_dresp
);

    tu_k0_t k0;
    logic   op_seen;

    // fixed segment mapping, no tlb
    function automatic tu_addr_resp_t translate(input logic [31:0] vaddr, input tu_k0_t k0_cur);
        tu_addr_resp_t r;
        r.paddr       = vaddr;
        r.is_uncached = 1'b0;
        if (vaddr[31:29] == SEG_KSEG0) begin
            r.paddr       = vaddr & SEG_MASK;
            r.is_uncached = (k0_cur != K0_CACHED);
        end else if (vaddr[31:29] == SEG_KSEG1) begin
            r.paddr       = vaddr & SEG_MASK;
            r.is_uncached = 1'b1;  // kseg1 never cached
        end
        return r;
    endfunction

    always_ff @(posedge aclk) begin
        if (aresetn) begin
            k0      <= K0_RESET;
            op_seen <= 1'b0;
        end else begin
            op_seen <= (i_op.op != TU_OP_NONE);  // read and set both answer
            if (i_op.op == TU_OP_SET_K0) begin
                k0 <= i_op.k0;
            end
        end
    end

    // response carries k0 after the op took effect
    assign o_op_resp.valid = op_seen;
    assign o_op_resp.k0    = k0;

    assign o_iresp = translate(i_ireq.vaddr, k0);
    assign o_dresp = translate(i_dreq.vaddr, k0);

endmodule

/* design/mmu.sv */
`timescale 1ns/10ps

module mmu import sramx_pkg::*, tu_pkg::*; (
    input  logic        aclk,
    input  logic        aresetn,
    input  tu_op_req_t  i_tu_op,
    output tu_op_resp_t o_tu_op_resp,
    input  sramx_req_t  i_imem_req,
    output sramx_resp_t o_imem_resp,
    input  sramx_req_t  i_dmem_req,
    output sramx_resp_t o_dmem_resp,
    output sramx_req_t  o_ifetch_req,
    input  sramx_resp_t i_ifetch_resp,
    output sramx_req_t  o_dcache_req,
    input  sramx_resp_t i_dcache_resp,
    output sramx_req_t  o_uncached_req,
    input  sramx_resp_t i_uncached_resp
);

    tu_addr_req_t  ireq, dreq;
    tu_addr_resp_t iresp, dresp;

    logic cur_finished;   // stage 1 already got addr_ok
    logic last_finished;  // stage 2 already got data_ok
    logic last_uncached;  // target of stage 2

    logic d_uncached;
    logic tgt_addr_ok;
    logic stage1_ready;
    logic stage2_ready;
    logic issue_ok;

    assign ireq.vaddr = i_imem_req.addr;
    assign dreq.vaddr = i_dmem_req.addr;

    translation_unit u_tu (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .i_op      (i_tu_op),
        .o_op_resp (o_tu_op_resp),
        .i_ireq    (ireq),
        .o_iresp   (iresp),
        .i_dreq    (dreq),
        .o_dresp   (dresp)
    );

    // instruction side, only the address changes
    always_comb begin
        o_ifetch_req      = i_imem_req;
        o_ifetch_req.addr = iresp.paddr;
    end
    assign o_imem_resp = i_ifetch_resp;

    assign d_uncached   = dresp.is_uncached;
    assign tgt_addr_ok  = d_uncached ? i_uncached_resp.addr_ok : i_dcache_resp.addr_ok;
    assign stage2_ready = last_finished || o_dmem_resp.data_ok;
    assign stage1_ready = stage2_ready && (cur_finished || tgt_addr_ok);

    // a second target only starts once stage 2 drains, so data_ok stays in order
    assign issue_ok = !cur_finished && (stage2_ready || (last_uncached == d_uncached));

    always_comb begin
        o_dcache_req   = '0;
        o_uncached_req = '0;
        if (d_uncached) begin
            o_uncached_req      = i_dmem_req;
            o_uncached_req.req  = i_dmem_req.req && issue_ok;
            o_uncached_req.addr = dresp.paddr;
        end else begin
            o_dcache_req      = i_dmem_req;
            o_dcache_req.req  = i_dmem_req.req && issue_ok;
            o_dcache_req.addr = dresp.paddr;
        end
    end

    assign o_dmem_resp.addr_ok = i_dmem_req.req && stage1_ready;
    assign o_dmem_resp.data_ok = last_uncached ? i_uncached_resp.data_ok : i_dcache_resp.data_ok;
    assign o_dmem_resp.rdata   = last_uncached ? i_uncached_resp.rdata : i_dcache_resp.rdata;

    always_ff @(posedge aclk) begin
        if (aresetn) begin
            cur_finished  <= 1'b0;
            last_finished <= 1'b1;
            last_uncached <= 1'b0;
        end else if (i_dmem_req.req && stage1_ready) begin
            // stage 1 moves into stage 2
            cur_finished  <= 1'b0;
            last_finished <= 1'b0;
            last_uncached <= d_uncached;
        end else begin
            if (i_dmem_req.req && !cur_finished) begin
                cur_finished <= tgt_addr_ok;
            end
            if (!last_finished) begin
                last_finished <= o_dmem_resp.data_ok;
            end
        end
    end

    // a response with nothing in stage 2 means a target answered out of turn
    a_no_stray_data_ok: assert property (@(posedge aclk) disable iff (aresetn)
        last_finished |-> !o_dmem_resp.data_ok);

endmodule

/* design/data_cache.sv */
`timescale 1ns/10ps

module data_cache import sramx_pkg::*; (
    input  logic        aclk,
    input  logic        aresetn,
    input  sramx_req_t  i_req,
    output sramx_resp_t o_resp,
    output sramx_req_t  o_mem_req,
    input  sramx_resp_t i_mem_resp
);

    typedef enum logic [1:0] {
        DC_IDLE,
        DC_HIT,
        DC_MEM_ADDR,
        DC_MEM_DATA
    } dc_state_e;

    dc_state_e state;

    logic [DC_LINES-1:0] line_valid;
    logic [DC_TAG_W-1:0] line_tag [DC_LINES];
    sramx_word_t         line_data [DC_LINES];

    sramx_req_t          pend;  // accepted access
    sramx_word_t         hit_data;
    logic [DC_IDX_W-1:0] req_idx, pend_idx;
    logic [DC_TAG_W-1:0] req_tag, pend_tag;
    logic                req_hit, pend_hit;

    assign req_idx  = i_req.addr[DC_IDX_W+1:2];
    assign req_tag  = i_req.addr[31:DC_IDX_W+2];
    assign pend_idx = pend.addr[DC_IDX_W+1:2];
    assign pend_tag = pend.addr[31:DC_IDX_W+2];
    assign req_hit  = line_valid[req_idx] && (line_tag[req_idx] == req_tag);
    assign pend_hit = line_valid[pend_idx] && (line_tag[pend_idx] == pend_tag);

    assign o_resp.addr_ok = i_req.req && (state == DC_IDLE);
    assign o_resp.data_ok = (state == DC_HIT) || ((state == DC_MEM_DATA) && i_mem_resp.data_ok);
    assign o_resp.rdata   = (state == DC_HIT) ? hit_data : i_mem_resp.rdata;

    always_comb begin
        o_mem_req     = pend;
        o_mem_req.req = (state == DC_MEM_ADDR);
    end

    always_ff @(posedge aclk) begin
        if (aresetn) begin
            state      <= DC_IDLE;
            line_valid <= '0;
        end else begin
            case (state)
                DC_IDLE: if (i_req.req) begin
                    state <= (!i_req.wr && req_hit) ? DC_HIT : DC_MEM_ADDR;
                end
                DC_HIT: state <= DC_IDLE;
                DC_MEM_ADDR: if (i_mem_resp.addr_ok) state <= DC_MEM_DATA;
                DC_MEM_DATA: if (i_mem_resp.data_ok) begin
                    state <= DC_IDLE;
                    if (!pend.wr) line_valid[pend_idx] <= 1'b1;  // refill
                end
                default: state <= DC_IDLE;
            endcase
        end
    end

    // accepted access and hit word
    always_ff @(posedge aclk) begin
        if (state == DC_IDLE && i_req.req) begin
            pend     <= i_req;
            hit_data <= line_data[req_idx];
        end
        if (state == DC_MEM_DATA && i_mem_resp.data_ok) begin
            if (!pend.wr) begin
                line_tag[pend_idx]  <= pend_tag;
                line_data[pend_idx] <= i_mem_resp.rdata;
            end else if (pend_hit) begin
                line_data[pend_idx] <= pend.wdata;  // write-through without allocate
            end
        end
    end

    // a hit neither raises a memory request nor gets a memory response
    a_hit_no_mem: assert property (@(posedge aclk) disable iff (aresetn)
        (state == DC_HIT) |-> !o_mem_req.req && !i_mem_resp.data_ok);

endmodule

/* design/mem_arbiter.sv */
`timescale 1ns/10ps

module mem_arbiter import sramx_pkg::*; (
    input  logic        aclk,
    input  logic        aresetn,
    input  sramx_req_t  i_ifetch_req,
    output sramx_resp_t o_ifetch_resp,
    input  sramx_req_t  i_dc_req,
    output sramx_resp_t o_dc_resp,
    input  sramx_req_t  i_unc_req,
    output sramx_resp_t o_unc_resp,
    output sramx_req_t  o_mem_req,
    input  sramx_resp_t i_mem_resp
);

    sramx_req_t  reqs  [ARB_MASTERS];
    sramx_resp_t resps [ARB_MASTERS];

    logic [1:0] rr_ptr;    // master with first priority
    logic [1:0] owner;
    logic       busy;      // grant locked to owner
    logic       accepted;  // owner's access got addr_ok
    logic [1:0] gnt_idx, cur_sel;
    logic       gnt_valid, cur_valid;

    assign reqs[0]       = i_ifetch_req;
    assign reqs[1]       = i_dc_req;
    assign reqs[2]       = i_unc_req;
    assign o_ifetch_resp = resps[0];
    assign o_dc_resp     = resps[1];
    assign o_unc_resp    = resps[2];

    always_comb begin
        int cand;
        gnt_valid = 1'b0;
        gnt_idx   = rr_ptr;
        for (int k = ARB_MASTERS - 1; k >= 0; k--) begin  // lowest offset wins
            cand = (int'(rr_ptr) + k) % ARB_MASTERS;
            if (reqs[cand].req) begin
                gnt_valid = 1'b1;
                gnt_idx   = 2'(cand);
            end
        end
    end

    assign cur_sel   = busy ? owner : gnt_idx;
    assign cur_valid = busy ? !accepted : gnt_valid;

    always_comb begin
        o_mem_req     = cur_valid ? reqs[cur_sel] : '0;
        o_mem_req.req = cur_valid && reqs[cur_sel].req;
        for (int m = 0; m < ARB_MASTERS; m++) begin
            resps[m].addr_ok = o_mem_req.req && (cur_sel == 2'(m)) && i_mem_resp.addr_ok;
            resps[m].data_ok = busy && (owner == 2'(m)) && i_mem_resp.data_ok;
            resps[m].rdata   = (busy && owner == 2'(m)) ? i_mem_resp.rdata : '0;
        end
    end

    always_ff @(posedge aclk) begin
        if (aresetn) begin
            rr_ptr   <= 2'd0;
            owner    <= 2'd0;
            busy     <= 1'b0;
            accepted <= 1'b0;
        end else if (!busy) begin
            if (gnt_valid) begin
                busy     <= 1'b1;
                owner    <= gnt_idx;
                accepted <= i_mem_resp.addr_ok;
            end
        end else if (!accepted) begin
            accepted <= i_mem_resp.addr_ok;
        end else if (i_mem_resp.data_ok) begin
            busy   <= 1'b0;
            rr_ptr <= (owner == 2'(ARB_MASTERS - 1)) ? 2'd0 : owner + 2'd1;
        end
    end

    a_data_ok_busy: assert property (@(posedge aclk) disable iff (aresetn)
        i_mem_resp.data_ok |-> busy);

endmodule

/* design/mmu_top.sv */
`timescale 1ns/10ps

module mmu_top import sramx_pkg::*, tu_pkg::*; (
    input  logic        aclk,
    input  logic        aresetn,
    input  tu_op_req_t  i_tu_op,
    output tu_op_resp_t o_tu_op_resp,
    input  sramx_req_t  i_imem_req,
    output sramx_resp_t o_imem_resp,
    input  sramx_req_t  i_dmem_req,
    output sramx_resp_t o_dmem_resp,
    output sramx_req_t  o_mem_req,
    input  sramx_resp_t i_mem_resp
);

    sramx_req_t  ifetch_req, dcache_req, uncached_req, refill_req;
    sramx_resp_t ifetch_resp, dcache_resp, uncached_resp, refill_resp;

    mmu u_mmu (
        .aclk            (aclk),
        .aresetn         (aresetn),
        .i_tu_op         (i_tu_op),
        .o_tu_op_resp    (o_tu_op_resp),
        .i_imem_req      (i_imem_req),
        .o_imem_resp     (o_imem_resp),
        .i_dmem_req      (i_dmem_req),
        .o_dmem_resp     (o_dmem_resp),
        .o_ifetch_req    (ifetch_req),
        .i_ifetch_resp   (ifetch_resp),
        .o_dcache_req    (dcache_req),
        .i_dcache_resp   (dcache_resp),
        .o_uncached_req  (uncached_req),
        .i_uncached_resp (uncached_resp)
    );

    data_cache u_dcache (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .i_req      (dcache_req),
        .o_resp     (dcache_resp),
        .o_mem_req  (refill_req),  // refill and write-through
        .i_mem_resp (refill_resp)
    );

    // port 0 ifetch, port 1 dcache, port 2 uncached
    mem_arbiter u_arb (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .i_ifetch_req  (ifetch_req),
        .o_ifetch_resp (ifetch_resp),
        .i_dc_req      (refill_req),
        .o_dc_resp     (refill_resp),
        .i_unc_req     (uncached_req),
        .o_unc_resp    (uncached_resp),
        .o_mem_req     (o_mem_req),
        .i_mem_resp    (i_mem_resp)
    );

endmodule

/* tests/tb_mmu_top.sv */
`timescale 1ns/10ps

module tb_mmu_top import sramx_pkg::*, tu_pkg::*; ();

    localparam int WAIT_LIMIT = 200;  // cycles allowed per wait loop

    // one expected cpu-side response
    typedef struct packed {
        logic        is_rd;
        logic [31:0] data;
    } exp_t;

    // one access on the memory port
    typedef struct packed {
        logic        wr;
        logic [31:0] addr;
        logic [31:0] wdata;
    } mem_acc_t;

    logic        aclk;
    logic        aresetn;
    tu_op_req_t  i_tu_op;
    tu_op_resp_t o_tu_op_resp;
    sramx_req_t  i_imem_req, i_dmem_req, o_mem_req;
    sramx_resp_t o_imem_resp, o_dmem_resp, i_mem_resp;

    integer seed_mem  = 32'h5de12eed;
    integer seed_dmem = 32'h5de12eed + 1;
    integer seed_imem = 32'h5de12eed + 2;

    int err_count;
    int check_count;
    int tests_run;
    int test_err_base;

    logic [31:0] mem [logic [31:0]];  // memory model storage
    logic        mem_busy;
    int          mem_wait;
    mem_acc_t    mem_cur;
    mem_acc_t    mem_seen_q [$];

    logic [31:0] ref_mem [logic [31:0]];  // mirror of memory, updated in issue order
    logic        ref_valid [DC_LINES];
    logic [31:0] ref_line_addr [DC_LINES];
    logic [31:0] ref_line_data [DC_LINES];
    tu_k0_t      ref_k0;
    mem_acc_t    mem_exp_q [$];
    exp_t        dexp_q [$];
    exp_t        iexp_q [$];
    exp_t        d_exp, i_exp;

    mmu_top DUT (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .i_tu_op      (i_tu_op),
        .o_tu_op_resp (o_tu_op_resp),
        .i_imem_req   (i_imem_req),
        .o_imem_resp  (o_imem_resp),
        .i_dmem_req   (i_dmem_req),
        .o_dmem_resp  (o_dmem_resp),
        .o_mem_req    (o_mem_req),
        .i_mem_resp   (i_mem_resp)
    );

    always #4 aclk = ~aclk;

    // contents of a word never written
    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return {a[15:0], a[31:16]} ^ 32'h6a09_e667;
    endfunction

    function automatic logic [31:0] mirror_word(input logic [31:0] a);
        return ref_mem.exists(a) ? ref_mem[a] : fill_word(a);
    endfunction

    // fixed segments: kseg0 and kseg1 drop the top three bits
    function automatic logic [31:0] ref_translate(input logic [31:0] vaddr, output logic unc);
        logic [31:0] paddr;
        paddr = vaddr;
        unc   = 1'b0;
        if (vaddr >= 32'h8000_0000 && vaddr <= 32'h9fff_ffff) begin
            paddr = vaddr & SEG_MASK;
            unc   = (ref_k0 != K0_CACHED);
        end else if (vaddr >= 32'ha000_0000 && vaddr <= 32'hbfff_ffff) begin
            paddr = vaddr & SEG_MASK;
            unc   = 1'b1;
        end
        return paddr;
    endfunction

    // predicts read data and memory traffic of one data access
    function automatic logic [31:0] ref_access(input logic wr, input logic [31:0] vaddr,
                                               input logic [31:0] wdata);
        logic [31:0] paddr;
        logic        unc;
        logic [3:0]  idx;
        logic        hit;
        logic [31:0] rdata;
        mem_acc_t    m;
        paddr = ref_translate(vaddr, unc);
        idx   = paddr[5:2];
        hit   = !unc && ref_valid[idx] && (ref_line_addr[idx] == paddr);
        rdata = mirror_word(paddr);
        m.wr    = wr;
        m.addr  = paddr;
        m.wdata = wdata;
        if (wr) begin
            ref_mem[paddr] = wdata;
            if (hit) begin
                ref_line_data[idx] = wdata;
            end
            mem_exp_q.push_back(m);
        end else if (hit) begin
            rdata = ref_line_data[idx];  // may be stale after an uncached write
        end else begin
            mem_exp_q.push_back(m);
            if (!unc) begin
                ref_valid[idx]     = 1'b1;
                ref_line_addr[idx] = paddr;
                ref_line_data[idx] = rdata;
            end
        end
        return rdata;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
            err_count++;
        end
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (err_count == test_err_base) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            $display("test %0d %s: %0d errors", tests_run, name, err_count - test_err_base);
        end
        test_err_base = err_count;
    endtask

    // strobe one op, answer is due exactly one cycle later
    task automatic tu_operation(input tu_op_e op, input tu_k0_t k0);
        i_tu_op.op = op;
        i_tu_op.k0 = k0;
        @(posedge aclk);
        compare_value("o_tu_op_resp.valid", o_tu_op_resp.valid, 1'b0);
        @(negedge aclk);
        i_tu_op.op = TU_OP_NONE;
        if (op == TU_OP_SET_K0) begin
            ref_k0 = k0;
        end
        @(posedge aclk);
        compare_value("o_tu_op_resp.valid", o_tu_op_resp.valid, 1'b1);
        compare_value("o_tu_op_resp.k0", o_tu_op_resp.k0, ref_k0);
        @(negedge aclk);
    endtask

    task automatic dmem_access(input logic wr, input logic [31:0] vaddr,
                               input logic [31:0] wdata);
        int   n;
        exp_t e;
        i_dmem_req.req   = 1'b1;
        i_dmem_req.wr    = wr;
        i_dmem_req.addr  = vaddr;
        i_dmem_req.wdata = wdata;
        n = 0;
        @(posedge aclk);
        while (!o_dmem_resp.addr_ok && n < WAIT_LIMIT) begin
            n++;
            @(posedge aclk);
        end
        if (o_dmem_resp.addr_ok) begin
            e.is_rd = !wr;
            e.data  = ref_access(wr, vaddr, wdata);
            dexp_q.push_back(e);
        end else begin
            $display("timeout: data request to %h was never accepted", vaddr);
            err_count++;
        end
        @(negedge aclk);
        i_dmem_req.req = 1'b0;
    endtask

    task automatic imem_fetch(input logic [31:0] vaddr);
        int          n;
        logic        unc;
        logic [31:0] paddr;
        exp_t        e;
        i_imem_req.req  = 1'b1;
        i_imem_req.wr   = 1'b0;
        i_imem_req.addr = vaddr;
        n = 0;
        @(posedge aclk);
        while (!o_imem_resp.addr_ok && n < WAIT_LIMIT) begin
            n++;
            @(posedge aclk);
        end
        if (o_imem_resp.addr_ok) begin
            paddr   = ref_translate(vaddr, unc);
            e.is_rd = 1'b1;
            e.data  = mirror_word(paddr);
            iexp_q.push_back(e);
        end else begin
            $display("timeout: instruction fetch at %h was never accepted", vaddr);
            err_count++;
        end
        @(negedge aclk);
        i_imem_req.req = 1'b0;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while ((dexp_q.size() > 0 || iexp_q.size() > 0) && n < WAIT_LIMIT) begin
            n++;
            @(negedge aclk);
        end
        if (dexp_q.size() > 0 || iexp_q.size() > 0) begin
            $display("timeout: %0d data and %0d instruction responses never arrived",
                     dexp_q.size(), iexp_q.size());
            err_count++;
            dexp_q.delete();
            iexp_q.delete();
        end
    endtask

    task automatic check_mem_traffic();
        mem_acc_t s;
        mem_acc_t e;
        compare_value("memory request count", mem_seen_q.size(), mem_exp_q.size());
        while (mem_seen_q.size() > 0 && mem_exp_q.size() > 0) begin
            s = mem_seen_q.pop_front();
            e = mem_exp_q.pop_front();
            compare_value("o_mem_req.addr", s.addr, e.addr);
            compare_value("o_mem_req.wr", s.wr, e.wr);
            if (e.wr) begin
                compare_value("o_mem_req.wdata", s.wdata, e.wdata);
            end
        end
        mem_seen_q.delete();
        mem_exp_q.delete();
    endtask

    task automatic run_dmem_traffic(input int count);
        logic [31:0] rnd;
        logic [31:0] base;
        for (int n = 0; n < count; n++) begin
            rnd = $random(seed_dmem);
            case (rnd[1:0])
                2'd0:    base = 32'h8000_2000;
                2'd1:    base = 32'ha000_2000;
                default: base = 32'h0000_2000;  // aliases kseg0 physically
            endcase
            dmem_access(rnd[8], base + (rnd & 32'h0000_007c), $random(seed_dmem));
            if (rnd[11:10] == 2'd0) begin
                @(negedge aclk);  // idle gap
            end
        end
    endtask

    task automatic run_imem_traffic(input int count);
        logic [31:0] rnd;
        for (int n = 0; n < count; n++) begin
            rnd = $random(seed_imem);
            imem_fetch((rnd[0] ? 32'hbfc0_0000 : 32'h8000_1000) + (rnd & 32'h0000_00fc));
            if (rnd[9:8] == 2'd0) begin
                @(negedge aclk);
            end
        end
    endtask

    // memory: accept on addr_ok, answer 1 to 3 cycles later
    always @(posedge aclk) begin
        if (aresetn) begin
            mem_busy = 1'b0;
        end else begin
            if (mem_busy && i_mem_resp.data_ok) begin
                if (mem_cur.wr) begin
                    mem[mem_cur.addr] = mem_cur.wdata;
                end
                mem_busy = 1'b0;
            end
            if (o_mem_req.req && i_mem_resp.addr_ok) begin
                mem_cur.wr    = o_mem_req.wr;
                mem_cur.addr  = o_mem_req.addr;
                mem_cur.wdata = o_mem_req.wdata;
                mem_seen_q.push_back(mem_cur);
                mem_busy = 1'b1;
                mem_wait = 1 + ($unsigned($random(seed_mem)) % 3);
            end
        end
    end

    always @(negedge aclk) begin
        i_mem_resp = '0;
        if (!aresetn && mem_busy) begin
            mem_wait--;
            if (mem_wait == 0) begin
                i_mem_resp.data_ok = 1'b1;
                i_mem_resp.rdata   = mem.exists(mem_cur.addr) ? mem[mem_cur.addr]
                                                              : fill_word(mem_cur.addr);
            end
        end else if (!aresetn) begin
            i_mem_resp.addr_ok = ($random(seed_mem) & 3) != 0;  // random stall
        end
    end

    // responses must come back in request order
    always @(posedge aclk) begin
        if (!aresetn && o_dmem_resp.data_ok) begin
            if (dexp_q.size() == 0) begin
                $display("data response arrived with no data access outstanding");
                err_count++;
            end else begin
                d_exp = dexp_q.pop_front();
                if (d_exp.is_rd) begin
                    compare_value("o_dmem_resp.rdata", o_dmem_resp.rdata, d_exp.data);
                end
            end
        end
        if (!aresetn && o_imem_resp.data_ok) begin
            if (iexp_q.size() == 0) begin
                $display("instruction response arrived with no fetch outstanding");
                err_count++;
            end else begin
                i_exp = iexp_q.pop_front();
                compare_value("o_imem_resp.rdata", o_imem_resp.rdata, i_exp.data);
            end
        end
    end

    initial begin
        aclk       = 1'b0;
        aresetn    = 1'b1;
        i_tu_op.op = TU_OP_NONE;
        i_tu_op.k0 = '0;
        i_imem_req = '0;
        i_dmem_req = '0;
        i_mem_resp = '0;
        err_count     = 0;
        check_count   = 0;
        tests_run     = 0;
        test_err_base = 0;
        ref_k0        = K0_RESET;
        for (int k = 0; k < DC_LINES; k++) begin
            ref_valid[k] = 1'b0;
        end
        repeat (8) @(posedge aclk);
        @(negedge aclk);
        aresetn = 1'b0;

        repeat (10) begin
            @(posedge aclk);
            compare_value("o_mem_req.req", o_mem_req.req, 1'b0);
            compare_value("o_dmem_resp.data_ok", o_dmem_resp.data_ok, 1'b0);
            compare_value("o_tu_op_resp.valid", o_tu_op_resp.valid, 1'b0);
        end
        @(negedge aclk);
        tu_operation(TU_OP_READ_K0, 3'd0);
        check_mem_traffic();
        report_test("reset and k0 readback");

        for (int k = 0; k < 6; k++) begin
            dmem_access(1'b0, 32'ha000_0100 + 32'(k * 4), 32'h0);
        end
        wait_drain();
        check_mem_traffic();
        report_test("kseg1 uncached reads");

        dmem_access(1'b0, 32'h8000_0200, 32'h0);
        dmem_access(1'b0, 32'h8000_0200, 32'h0);  // hit
        dmem_access(1'b0, 32'h8000_0240, 32'h0);  // same index, other tag
        dmem_access(1'b0, 32'h8000_0200, 32'h0);
        wait_drain();
        check_mem_traffic();
        report_test("kseg0 hits and refill");

        tu_operation(TU_OP_SET_K0, 3'd2);
        repeat (2) dmem_access(1'b0, 32'h8000_0300, 32'h0);
        wait_drain();
        tu_operation(TU_OP_SET_K0, 3'd3);
        repeat (3) dmem_access(1'b0, 32'h8000_0300, 32'h0);
        wait_drain();
        check_mem_traffic();
        report_test("k0 switches kseg0 caching");

        dmem_access(1'b1, 32'h8000_0400, 32'h1111_0400);  // write miss, no allocate
        dmem_access(1'b0, 32'h8000_0400, 32'h0);
        dmem_access(1'b1, 32'h8000_0400, 32'h2222_0400);  // write hit
        dmem_access(1'b0, 32'h8000_0400, 32'h0);
        dmem_access(1'b1, 32'ha000_0500, 32'h3333_0500);
        dmem_access(1'b0, 32'ha000_0500, 32'h0);
        dmem_access(1'b0, 32'h8000_0500, 32'h0);
        dmem_access(1'b0, 32'ha000_0400, 32'h0);
        wait_drain();
        check_mem_traffic();
        report_test("write-through");

        fork
            run_dmem_traffic(80);
            run_imem_traffic(50);
        join
        wait_drain();
        mem_seen_q.delete();  // fetches interleave freely with data traffic
        mem_exp_q.delete();
        report_test("mixed random traffic");

        $display("tests %0d, checks %0d, errors %0d", tests_run, check_count, err_count);
        if (err_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* list.f */
design/sramx_pkg.sv
design/tu_pkg.sv
design/translation_unit.sv
design/mmu.sv
design/data_cache.sv
design/mem_arbiter.sv
design/mmu_top.sv
tests/tb_mmu_top.sv

/* Makefile */
SIM = obj_dir/Vtb_mmu_top

.PHONY: compile run clean

compile: $(SIM)

$(SIM): list.f design/*.sv tests/*.sv
	verilator --binary --timing --assert -Wno-fatal --top-module tb_mmu_top \
		-f list.f -o Vtb_mmu_top

run: $(SIM)
	./$(SIM) > sim.log 2>&1; cat sim.log
	@if grep -q "Simulation FAILED" sim.log; then exit 1; fi
	@grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
